//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mips_ctrl
FILELIST  ?= mips_ctrl.f
OBJ_DIR   ?= obj_dir
RUN_FLAGS ?= +verilator+error+limit+1000
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- mips_ctrl.f
hw/mips_ctrl_pkg.sv
hw/instr_decode.sv
hw/exec_sequencer.sv
hw/ctrl_word_gen.sv
hw/mips_ctrl.sv
testbench/mips_ctrl_asserts.sv
testbench/tb_mips_ctrl.sv

//--- testbench/tb_mips_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_ctrl
    import mips_ctrl_pkg::*;
;

    localparam int NUM_INSTR  = 150;
    localparam int IR_LIMIT   = 16;
    localparam int BODY_LIMIT = 40;
    localparam int INIT_LIMIT = 8;

    // Instruction kinds picked by the generator
    localparam int K_ADD   = 0;
    localparam int K_SUB   = 1;
    localparam int K_AND   = 2;
    localparam int K_ADDI  = 3;
    localparam int K_ADDIU = 4;
    localparam int K_LW    = 5;
    localparam int K_LH    = 6;
    localparam int K_LB    = 7;
    localparam int K_SW    = 8;
    localparam int K_SH    = 9;
    localparam int K_SB    = 10;
    localparam int K_BAD   = 11;

    logic        clk;
    logic        reset   = 1'b1;
    instr_t      instr   = '0;
    logic        ov      = 1'b0;
    logic        mem_ack = 1'b0;
    logic        mem_req;
    logic        mem_wr;
    iord_t       iord;
    logic        pc_write;
    logic        ir_write;
    logic        a_write;
    logic        b_write;
    logic        mdr_write;
    logic        alu_out_write;
    logic        epc_write;
    logic        reg_write;
    reg_dst_t    reg_dst;
    mem_to_reg_t mem_to_reg;
    mem_size_t   mdr_sel;
    mem_size_t   store_sel;
    alu_src_a_t  alu_src_a;
    alu_src_b_t  alu_src_b;
    alu_op_t     alu_op;
    pc_src_t     pc_src;
    exc_cause_t  except_cause;

    integer seed = 32'h39af4893;
    int     ack_wait = 0;
    int     cur_kind = 0;
    logic   prev_req = 1'b0;
    logic   req_rise = 1'b0;
    bit     timed_out = 1'b0;
    string  test_name = "";
    int     test_errors = 0;
    int     error_count = 0;
    int     check_count = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     total_errors;

    mips_ctrl mips_ctrl_inst (
        .clk (clk), .reset (reset), .instr (instr), .ov (ov), .mem_ack (mem_ack),
        .mem_req (mem_req), .mem_wr (mem_wr), .iord (iord),
        .pc_write (pc_write), .ir_write (ir_write), .a_write (a_write),
        .b_write (b_write), .mdr_write (mdr_write), .alu_out_write (alu_out_write),
        .epc_write (epc_write), .reg_write (reg_write), .reg_dst (reg_dst),
        .mem_to_reg (mem_to_reg), .mdr_sel (mdr_sel), .store_sel (store_sel),
        .alu_src_a (alu_src_a), .alu_src_b (alu_src_b), .alu_op (alu_op),
        .pc_src (pc_src), .except_cause (except_cause)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        rand_below = $unsigned($random(seed)) % n;
    endfunction

    function automatic bit opcode_known(input logic [5:0] op);
        opcode_known = (op == OPC_RTYPE) || (op == OPC_ADDI) || (op == OPC_ADDIU) ||
                       (op == OPC_LW) || (op == OPC_LH) || (op == OPC_LB) ||
                       (op == OPC_SW) || (op == OPC_SH) || (op == OPC_SB);
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            K_ADD:   kind_name = "add";
            K_SUB:   kind_name = "sub";
            K_AND:   kind_name = "and";
            K_ADDI:  kind_name = "addi";
            K_ADDIU: kind_name = "addiu";
            K_LW:    kind_name = "lw";
            K_LH:    kind_name = "lh";
            K_LB:    kind_name = "lb";
            K_SW:    kind_name = "sw";
            K_SH:    kind_name = "sh";
            K_SB:    kind_name = "sb";
            default: kind_name = "illegal";
        endcase
    endfunction

    // Random register fields, opcode and funct forced to the kind
    function automatic instr_t make_word(input int kind);
        instr_t w;
        w = $random(seed);
        case (kind)
            K_ADD:   w.r = '{OPC_RTYPE, w.r.rs, w.r.rt, w.r.rd, w.r.shamt, FUNCT_ADD};
            K_SUB:   w.r = '{OPC_RTYPE, w.r.rs, w.r.rt, w.r.rd, w.r.shamt, FUNCT_SUB};
            K_AND:   w.r = '{OPC_RTYPE, w.r.rs, w.r.rt, w.r.rd, w.r.shamt, FUNCT_AND};
            K_ADDI:  w.i.opcode = OPC_ADDI;
            K_ADDIU: w.i.opcode = OPC_ADDIU;
            K_LW:    w.i.opcode = OPC_LW;
            K_LH:    w.i.opcode = OPC_LH;
            K_LB:    w.i.opcode = OPC_LB;
            K_SW:    w.i.opcode = OPC_SW;
            K_SH:    w.i.opcode = OPC_SH;
            K_SB:    w.i.opcode = OPC_SB;
            default: begin
                if (rand_below(2) == 0) begin
                    w.r.opcode = OPC_RTYPE;
                    if (w.r.funct == FUNCT_ADD || w.r.funct == FUNCT_SUB ||
                        w.r.funct == FUNCT_AND) begin
                        w.r.funct = 6'h00;
                    end
                end else if (opcode_known(w.i.opcode)) begin
                    w.i.opcode = 6'h3f;
                end
            end
        endcase
        return w;
    endfunction

    // Memory responder and IR loader
    always @(posedge clk) begin
        int kind;
        if (reset) begin
            mem_ack  <= 1'b0;
            ack_wait <= rand_below(4);
        end else begin
            if (!mem_ack) begin
                if (mem_req) begin
                    if (ack_wait == 0) begin
                        mem_ack  <= 1'b1;
                        ack_wait <= rand_below(4);
                    end else begin
                        ack_wait <= ack_wait - 1;
                    end
                end
            end else if (!mem_req) begin
                if (ack_wait == 0) begin
                    mem_ack  <= 1'b0;
                    ack_wait <= rand_below(4);
                end else begin
                    ack_wait <= ack_wait - 1;
                end
            end
            if (ir_write) begin
                kind = (rand_below(8) == 0) ? K_BAD : rand_below(11);
                instr    <= make_word(kind);
                cur_kind <= kind;
                ov       <= (rand_below(2) == 1);
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    // Outputs are sampled on the falling edge
    task automatic step();
        @(negedge clk);
        req_rise = mem_req && !prev_req;
        prev_req = mem_req;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("%s: %s", test_name, (test_errors == 0) ? "ok" : "FAILED");
    endtask

    task automatic reset_init_test();
        int waited;
        test_name = "reset_init";
        test_errors = 0;
        repeat (9) @(posedge clk);
        step();
        check_value("mem_req in reset", 0, 32'(mem_req));
        check_value("reg_write in reset", 0, 32'(reg_write));
        check_value("pc_write in reset", 0, 32'(pc_write));
        @(posedge clk);
        reset <= 1'b0;
        waited = 0;
        step();
        while (!reg_write && waited < INIT_LIMIT) begin
            step();
            waited++;
        end
        if (!reg_write) begin
            $display("Timeout: no stack pointer write after reset was released");
            timed_out = 1'b1;
        end else begin
            check_value("reg_dst", 32'(DST_SP), 32'(reg_dst));
            check_value("mem_to_reg", 32'(WB_STACK_TOP), 32'(mem_to_reg));
            check_value("mem_req at init", 0, 32'(mem_req));
            step();
            check_value("fetch mem_req", 1, 32'(req_rise));
            check_value("fetch iord", 32'(IORD_PC), 32'(iord));
            finish_test();
        end
    endtask

    task automatic run_instruction(input int idx);
        int          waited;
        int          kind;
        logic        ov_now;
        bit          done;
        bit          is_r;
        bit          is_load;
        bit          is_store;
        bit          is_bad;
        bit          traps;
        int          n_aluw;
        int          n_reg;
        int          n_epc;
        int          n_data;
        int          n_mdr;
        int          n_rise;
        int          n_opnd;
        int          cyc;
        int          mdr_cyc;
        int          reg_cyc;
        alu_op_t     exp_op;
        mem_size_t   exp_size;
        alu_op_t     got_op;
        alu_src_a_t  got_srca;
        alu_src_b_t  got_srcb;
        logic [1:0]  got_ab;
        reg_dst_t    got_dst;
        mem_to_reg_t got_wb;
        mem_size_t   got_msel;
        mem_size_t   got_ssel;
        logic        got_wr;
        exc_cause_t  got_cause;
        pc_src_t     got_pc_src;
        logic        got_pcw;

        test_errors = 0;
        test_name = $sformatf("instr_%0d", idx);
        n_aluw = 0;
        n_reg = 0;
        n_epc = 0;
        n_data = 0;
        n_mdr = 0;
        n_rise = 0;
        n_opnd = 0;
        cyc = 0;
        mdr_cyc = 0;
        reg_cyc = 0;
        done = 1'b0;
        check_value("fetch mem_wr", 0, 32'(mem_wr));

        waited = 0;
        while (!ir_write && waited < IR_LIMIT) begin
            step();
            waited++;
        end
        if (!ir_write) begin
            $display("Timeout: instruction %0d was never latched into the IR", idx);
            timed_out = 1'b1;
        end else begin
            // PC + 4 goes through the ALU while the IR loads
            check_value("latch pc_write", 1, 32'(pc_write));
            check_value("latch alu_src_a", 32'(SRCA_PC), 32'(alu_src_a));
            check_value("latch alu_src_b", 32'(SRCB_FOUR), 32'(alu_src_b));
            check_value("latch alu_op", 32'(ALU_ADD), 32'(alu_op));
            check_value("latch pc_src", 32'(PC_ALU), 32'(pc_src));
            step();
            kind = cur_kind;
            ov_now = ov;
            test_name = $sformatf("instr_%0d_%s%s", idx, kind_name(kind), ov_now ? "_ov" : "");
            waited = 0;
            while (!done && waited < BODY_LIMIT) begin
                if (req_rise && iord == IORD_PC) begin
                    done = 1'b1;
                end else begin
                    cyc++;
                    if (req_rise) begin
                        n_rise++;
                    end
                    if (req_rise && iord == IORD_ALU_OUT) begin
                        n_data++;
                        got_wr = mem_wr;
                        got_ssel = store_sel;
                    end
                    if (a_write || b_write) begin
                        n_opnd++;
                        got_ab = {a_write, b_write};
                    end
                    if (alu_out_write) begin
                        n_aluw++;
                        got_op = alu_op;
                        got_srca = alu_src_a;
                        got_srcb = alu_src_b;
                    end
                    if (mdr_write) begin
                        n_mdr++;
                        mdr_cyc = cyc;
                    end
                    if (reg_write) begin
                        n_reg++;
                        reg_cyc = cyc;
                        got_dst = reg_dst;
                        got_wb = mem_to_reg;
                        got_msel = mdr_sel;
                    end
                    if (epc_write) begin
                        n_epc++;
                        got_cause = except_cause;
                        got_pc_src = pc_src;
                        got_pcw = pc_write;
                    end
                    step();
                    waited++;
                end
            end
            if (!done) begin
                $display("Timeout: instruction %0d never reached the next fetch", idx);
                timed_out = 1'b1;
            end else begin
                is_r = (kind <= K_AND);
                is_load = (kind >= K_LW) && (kind <= K_LB);
                is_store = (kind >= K_SW) && (kind <= K_SB);
                is_bad = (kind == K_BAD);
                traps = (kind == K_ADD || kind == K_SUB || kind == K_ADDI) && ov_now;
                exp_op = (kind == K_SUB) ? ALU_SUB : ((kind == K_AND) ? ALU_AND : ALU_ADD);
                exp_size = (kind == K_LH || kind == K_SH) ? SZ_HALF :
                           ((kind == K_LB || kind == K_SB) ? SZ_BYTE : SZ_WORD);

                check_value("operand latch count", 1, n_opnd);
                check_value("a_write and b_write", 3, 32'(got_ab));
                check_value("alu_out_write count", 32'(!is_bad), n_aluw);
                if (!is_bad) begin
                    check_value("alu_op", 32'(exp_op), 32'(got_op));
                    check_value("alu_src_a", 32'(SRCA_A), 32'(got_srca));
                    check_value("alu_src_b", 32'(is_r ? SRCB_B : SRCB_IMM), 32'(got_srcb));
                end
                check_value("reg_write count", 32'(!is_bad && !is_store && !traps), n_reg);
                if (!is_bad && !is_store && !traps) begin
                    check_value("reg_dst", 32'(is_r ? DST_RD : DST_RT), 32'(got_dst));
                    check_value("mem_to_reg", 32'(is_load ? WB_MDR : WB_ALU_OUT),
                                32'(got_wb));
                end
                check_value("mdr_write count", 32'(is_load), n_mdr);
                if (is_load) begin
                    check_value("mdr_sel", 32'(exp_size), 32'(got_msel));
                    check_value("mdr_write before reg_write", 1, 32'(mdr_cyc < reg_cyc));
                end
                check_value("data access count", 32'(is_load || is_store), n_data);
                if (is_load || is_store) begin
                    check_value("mem_wr", 32'(is_store), 32'(got_wr));
                end
                if (is_store) begin
                    check_value("store_sel", 32'(exp_size), 32'(got_ssel));
                end
                check_value("epc_write count", 32'(is_bad || traps), n_epc);
                if (is_bad || traps) begin
                    check_value("except_cause", 32'(is_bad ? EXC_NO_OPCODE : EXC_OVERFLOW),
                                32'(got_cause));
                    check_value("pc_src", 32'(PC_EXC_VECTOR), 32'(got_pc_src));
                    check_value("exception pc_write", 1, 32'(got_pcw));
                end
                check_value("mem_req rises", 32'(1 + (is_load || is_store)), 1 + n_rise);
                finish_test();
            end
        end
    endtask

    initial begin
        reset_init_test();
        for (int i = 0; i < NUM_INSTR && !timed_out; i++) begin
            run_instruction(i);
        end
        total_errors = error_count + int'(mips_ctrl_inst.mips_ctrl_asserts_inst.assert_failures);
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches, %0d assertion errors",
                 tests_run, tests_failed, check_count, error_count,
                 total_errors - error_count);
        if (total_errors == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/mips_ctrl_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mips_ctrl_asserts (
    input logic       clk,
    input logic       reset,
    input logic       mem_req,
    input logic       mem_ack,
    input logic       mem_wr,
    input logic [1:0] iord,
    input logic       pc_write,
    input logic       ir_write,
    input logic       a_write,
    input logic       b_write,
    input logic       mdr_write,
    input logic       alu_out_write,
    input logic       epc_write,
    input logic       reg_write
);

    int unsigned assert_failures = 0;
    logic        any_enable;

    assign any_enable = pc_write | ir_write | a_write | b_write | mdr_write |
                        alu_out_write | epc_write | reg_write;

    // Request and its qualifiers held until memory answers
    req_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_ack |=> mem_req && $stable(iord) && $stable(mem_wr))
        else begin
            $error("mem_req, iord or mem_wr changed before mem_ack");
            assert_failures++;
        end

    req_drop: assert property (@(posedge clk) disable iff (reset)
        mem_req && mem_ack |=> !mem_req)
        else begin
            $error("mem_req still high after mem_ack was seen");
            assert_failures++;
        end

    // No new request while the old acknowledge is still up
    req_rearm: assert property (@(posedge clk) disable iff (reset)
        !mem_req && mem_ack |=> !mem_req)
        else begin
            $error("mem_req raised before mem_ack went low");
            assert_failures++;
        end

    reset_quiet: assert property (@(posedge clk)
        reset && $past(reset) |-> !any_enable && !mem_req)
        else begin
            $error("enable or mem_req high during reset");
            assert_failures++;
        end

    single_end: assert property (@(posedge clk) disable iff (reset)
        !(reg_write && epc_write))
        else begin
            $error("reg_write and epc_write high together");
            assert_failures++;
        end

    wr_needs_req: assert property (@(posedge clk) disable iff (reset)
        mem_wr |-> mem_req)
        else begin
            $error("mem_wr high without mem_req");
            assert_failures++;
        end

endmodule

bind mips_ctrl mips_ctrl_asserts mips_ctrl_asserts_inst (
    .clk           (clk),
    .reset         (reset),
    .mem_req       (mem_req),
    .mem_ack       (mem_ack),
    .mem_wr        (mem_wr),
    .iord          (iord),
    .pc_write      (pc_write),
    .ir_write      (ir_write),
    .a_write       (a_write),
    .b_write       (b_write),
    .mdr_write     (mdr_write),
    .alu_out_write (alu_out_write),
    .epc_write     (epc_write),
    .reg_write     (reg_write)
);

`default_nettype wire

//--- hw/mips_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mips_ctrl
    import mips_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  instr_t      instr,
    input  logic        ov,
    input  logic        mem_ack,
    output logic        mem_req,
    output logic        mem_wr,
    output iord_t       iord,
    output logic        pc_write,
    output logic        ir_write,
    output logic        a_write,
    output logic        b_write,
    output logic        mdr_write,
    output logic        alu_out_write,
    output logic        epc_write,
    output logic        reg_write,
    output reg_dst_t    reg_dst,
    output mem_to_reg_t mem_to_reg,
    output mem_size_t   mdr_sel,
    output mem_size_t   store_sel,
    output alu_src_a_t  alu_src_a,
    output alu_src_b_t  alu_src_b,
    output alu_op_t     alu_op,
    output pc_src_t     pc_src,
    output exc_cause_t  except_cause
);

    op_class_t  op_class;
    alu_op_t    alu_fn;
    mem_size_t  mem_size;
    logic       check_ov;
    state_t     state;
    exc_cause_t exc_cause;

    instr_decode instr_decode_inst (
        .instr    (instr),
        .op_class (op_class),
        .alu_fn   (alu_fn),
        .mem_size (mem_size),
        .check_ov (check_ov)
    );

    exec_sequencer exec_sequencer_inst (
        .clk       (clk),
        .reset     (reset),
        .op_class  (op_class),
        .check_ov  (check_ov),
        .ov        (ov),
        .mem_ack   (mem_ack),
        .state     (state),
        .exc_cause (exc_cause)
    );

    ctrl_word_gen ctrl_word_gen_inst (
        .state         (state),
        .exc_cause     (exc_cause),
        .op_class      (op_class),
        .alu_fn        (alu_fn),
        .mem_size      (mem_size),
        .mem_req       (mem_req),
        .mem_wr        (mem_wr),
        .iord          (iord),
        .pc_write      (pc_write),
        .ir_write      (ir_write),
        .a_write       (a_write),
        .b_write       (b_write),
        .mdr_write     (mdr_write),
        .alu_out_write (alu_out_write),
        .epc_write     (epc_write),
        .reg_write     (reg_write),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg),
        .mdr_sel       (mdr_sel),
        .store_sel     (store_sel),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .pc_src        (pc_src),
        .except_cause  (except_cause)
    );

endmodule

`default_nettype wire

//--- hw/ctrl_word_gen.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_word_gen
    import mips_ctrl_pkg::*;
(
    input  state_t      state,
    input  exc_cause_t  exc_cause,
    input  op_class_t   op_class,
    input  alu_op_t     alu_fn,
    input  mem_size_t   mem_size,
    output logic        mem_req,
    output logic        mem_wr,
    output iord_t       iord,
    output logic        pc_write,
    output logic        ir_write,
    output logic        a_write,
    output logic        b_write,
    output logic        mdr_write,
    output logic        alu_out_write,
    output logic        epc_write,
    output logic        reg_write,
    output reg_dst_t    reg_dst,
    output mem_to_reg_t mem_to_reg,
    output mem_size_t   mdr_sel,
    output mem_size_t   store_sel,
    output alu_src_a_t  alu_src_a,
    output alu_src_b_t  alu_src_b,
    output alu_op_t     alu_op,
    output pc_src_t     pc_src,
    output exc_cause_t  except_cause
);

    always_comb begin
        mem_req       = 1'b0;
        mem_wr        = 1'b0;
        iord          = IORD_PC;
        pc_write      = 1'b0;
        ir_write      = 1'b0;
        a_write       = 1'b0;
        b_write       = 1'b0;
        mdr_write     = 1'b0;
        alu_out_write = 1'b0;
        epc_write     = 1'b0;
        reg_write     = 1'b0;
        reg_dst       = DST_RT;
        mem_to_reg    = WB_ALU_OUT;
        mdr_sel       = SZ_WORD;
        store_sel     = SZ_WORD;
        alu_src_a     = SRCA_PC;
        alu_src_b     = SRCB_B;
        alu_op        = ALU_ADD;
        pc_src        = PC_ALU;
        except_cause  = EXC_NONE;

        case (state)
            ST_INIT_SP: begin
                reg_write  = 1'b1;
                reg_dst    = DST_SP;
                mem_to_reg = WB_STACK_TOP;
            end
            ST_FETCH_REQ: begin
                mem_req = 1'b1;
                iord    = IORD_PC;
            end
            // IR takes the word while PC moves to PC + 4
            ST_FETCH_LATCH: begin
                ir_write  = 1'b1;
                pc_write  = 1'b1;
                alu_src_a = SRCA_PC;
                alu_src_b = SRCB_FOUR;
                alu_op    = ALU_ADD;
                pc_src    = PC_ALU;
            end
            ST_DECODE: begin
                a_write = 1'b1;
                b_write = 1'b1;
            end
            ST_ALU_EXEC: begin
                alu_out_write = 1'b1;
                alu_src_a     = SRCA_A;
                alu_op        = alu_fn;
                alu_src_b     = (op_class == OP_R_ALU) ? SRCB_B : SRCB_IMM;
            end
            ST_ALU_WB: begin
                reg_write  = 1'b1;
                reg_dst    = (op_class == OP_R_ALU) ? DST_RD : DST_RT;
                mem_to_reg = WB_ALU_OUT;
            end
            // Base plus offset
            ST_ADDR_CALC: begin
                alu_out_write = 1'b1;
                alu_src_a     = SRCA_A;
                alu_src_b     = SRCB_IMM;
                alu_op        = ALU_ADD;
            end
            ST_MEM_REQ: begin
                mem_req   = 1'b1;
                iord      = IORD_ALU_OUT;
                mem_wr    = (op_class == OP_STORE);
                store_sel = mem_size;
            end
            ST_MEM_LATCH: begin
                mdr_write = (op_class == OP_LOAD);
            end
            ST_LOAD_WB: begin
                reg_write  = 1'b1;
                reg_dst    = DST_RT;
                mem_to_reg = WB_MDR;
                mdr_sel    = mem_size;
            end
            ST_EXCEPT: begin
                epc_write    = 1'b1;
                pc_write     = 1'b1;
                pc_src       = PC_EXC_VECTOR;
                except_cause = exc_cause;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/exec_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module exec_sequencer
    import mips_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  op_class_t  op_class,
    input  logic       check_ov,
    input  logic       ov,
    input  logic       mem_ack,
    output state_t     state,
    output exc_cause_t exc_cause
);

    state_t     next_state;
    exc_cause_t next_cause;

    always_comb begin
        next_state = state;
        next_cause = exc_cause;

        case (state)
            ST_RESET:   next_state = ST_INIT_SP;
            ST_INIT_SP: next_state = ST_FETCH_REQ;

            // Hold request until memory answers
            ST_FETCH_REQ: begin
                if (mem_ack) begin
                    next_state = ST_FETCH_LATCH;
                end
            end
            ST_FETCH_LATCH: next_state = ST_FETCH_REL;
            ST_FETCH_REL: begin
                if (!mem_ack) begin
                    next_state = ST_DECODE;
                end
            end

            ST_DECODE: begin
                case (op_class)
                    OP_R_ALU, OP_I_ALU: next_state = ST_ALU_EXEC;
                    OP_LOAD, OP_STORE:  next_state = ST_ADDR_CALC;
                    default: begin
                        next_state = ST_EXCEPT;
                        next_cause = EXC_NO_OPCODE;
                    end
                endcase
            end

            // ALU result and its flag are valid in this cycle
            ST_ALU_EXEC: begin
                if (check_ov && ov) begin
                    next_state = ST_EXCEPT;
                    next_cause = EXC_OVERFLOW;
                end else begin
                    next_state = ST_ALU_WB;
                end
            end
            ST_ALU_WB: next_state = ST_FETCH_REQ;

            ST_ADDR_CALC: next_state = ST_MEM_REQ;
            ST_MEM_REQ: begin
                if (mem_ack) begin
                    next_state = ST_MEM_LATCH;
                end
            end
            ST_MEM_LATCH: next_state = ST_MEM_REL;
            ST_MEM_REL: begin
                if (!mem_ack) begin
                    if (op_class == OP_LOAD) begin
                        next_state = ST_LOAD_WB;
                    end else begin
                        next_state = ST_FETCH_REQ;
                    end
                end
            end
            ST_LOAD_WB: next_state = ST_FETCH_REQ;

            ST_EXCEPT: next_state = ST_FETCH_REQ;
            default:   next_state = ST_RESET;
        endcase
    end

    // Held in a quiet state while reset is asserted
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_RESET;
            exc_cause <= EXC_NONE;
        end else begin
            state     <= next_state;
            exc_cause <= next_cause;
        end
    end

endmodule

`default_nettype wire

//--- hw/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode
    import mips_ctrl_pkg::*;
(
    input  instr_t    instr,
    output op_class_t op_class,
    output alu_op_t   alu_fn,
    output mem_size_t mem_size,
    output logic      check_ov
);

    always_comb begin
        op_class = OP_ILLEGAL;
        alu_fn   = ALU_ADD;
        mem_size = SZ_WORD;
        check_ov = 1'b0;

        case (instr.i.opcode)
            OPC_RTYPE: begin
                case (instr.r.funct)
                    FUNCT_ADD: begin
                        op_class = OP_R_ALU;
                        check_ov = 1'b1;
                    end
                    FUNCT_SUB: begin
                        op_class = OP_R_ALU;
                        alu_fn   = ALU_SUB;
                        check_ov = 1'b1;
                    end
                    FUNCT_AND: begin
                        op_class = OP_R_ALU;
                        alu_fn   = ALU_AND;
                    end
                    default: op_class = OP_ILLEGAL;
                endcase
            end
            OPC_ADDI: begin
                op_class = OP_I_ALU;
                check_ov = 1'b1;
            end
            // Unsigned add never traps
            OPC_ADDIU: op_class = OP_I_ALU;
            OPC_LW:    op_class = OP_LOAD;
            OPC_LH: begin
                op_class = OP_LOAD;
                mem_size = SZ_HALF;
            end
            OPC_LB: begin
                op_class = OP_LOAD;
                mem_size = SZ_BYTE;
            end
            OPC_SW:    op_class = OP_STORE;
            OPC_SH: begin
                op_class = OP_STORE;
                mem_size = SZ_HALF;
            end
            OPC_SB: begin
                op_class = OP_STORE;
                mem_size = SZ_BYTE;
            end
            default:   op_class = OP_ILLEGAL;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

    // Opcodes
    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_ADDI  = 6'h08;
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_LB    = 6'h20;
    localparam logic [5:0] OPC_LH    = 6'h21;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_SB    = 6'h28;
    localparam logic [5:0] OPC_SH    = 6'h29;
    localparam logic [5:0] OPC_SW    = 6'h2b;

    // R-type funct field
    localparam logic [5:0] FUNCT_ADD = 6'h20;
    localparam logic [5:0] FUNCT_SUB = 6'h22;
    localparam logic [5:0] FUNCT_AND = 6'h24;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // Same IR word, two field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

    typedef enum logic [2:0] {
        OP_R_ALU,
        OP_I_ALU,
        OP_LOAD,
        OP_STORE,
        OP_ILLEGAL
    } op_class_t;

    typedef enum logic [2:0] {ALU_ADD, ALU_AND, ALU_SUB} alu_op_t;

    // Load MDR select and store B-to-memory select
    typedef enum logic [1:0] {SZ_WORD, SZ_HALF, SZ_BYTE} mem_size_t;

    typedef enum logic [3:0] {
        ST_RESET,
        ST_INIT_SP,
        ST_FETCH_REQ,
        ST_FETCH_LATCH,
        ST_FETCH_REL,
        ST_DECODE,
        ST_ALU_EXEC,
        ST_ALU_WB,
        ST_ADDR_CALC,
        ST_MEM_REQ,
        ST_MEM_LATCH,
        ST_MEM_REL,
        ST_LOAD_WB,
        ST_EXCEPT
    } state_t;

    typedef enum logic [1:0] {IORD_PC, IORD_ALU_OUT} iord_t;
    typedef enum logic [1:0] {DST_RT, DST_RD, DST_SP} reg_dst_t;
    typedef enum logic [1:0] {WB_ALU_OUT, WB_MDR, WB_STACK_TOP} mem_to_reg_t;
    typedef enum logic {SRCA_PC, SRCA_A} alu_src_a_t;
    typedef enum logic [1:0] {SRCB_B, SRCB_FOUR, SRCB_IMM} alu_src_b_t;
    typedef enum logic [1:0] {PC_ALU, PC_EXC_VECTOR} pc_src_t;
    typedef enum logic [1:0] {EXC_NONE, EXC_NO_OPCODE, EXC_OVERFLOW} exc_cause_t;

endpackage

`default_nettype wire
